// File: flist.f
hdl/exec_pkg.sv
hdl/result_queue.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/cdb_arbiter.sv
hdl/exec_cluster.sv
verification/exec_cluster_props.sv
verification/exec_cluster_tb.sv

// File: verification/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

  localparam int mult_stages = 4;
  localparam int queue_depth = 4;
  localparam int timeout     = 300;  // cycles per wait

  logic                        clock;
  logic                        reset;
  logic                        issue_valid;
  exec_pkg::fu_sel_e           issue_fu;
  exec_pkg::alu_op_e           issue_op;
  logic [63:0]                 issue_a;
  logic [63:0]                 issue_b;
  exec_pkg::preg_idx_t         issue_dest_preg;
  exec_pkg::rob_idx_t          issue_rob_idx;
  logic                        rollback_en;
  exec_pkg::rob_idx_t          rollback_rob_idx;
  exec_pkg::rob_idx_t          rob_head_idx;
  logic                        alu_ready;
  logic                        mult_ready;
  logic                        cdb_valid;
  exec_pkg::preg_idx_t         cdb_preg;
  logic [63:0]                 cdb_value;
  exec_pkg::rob_idx_t          cdb_rob_idx;
  logic                        cdb_taken;

  // scoreboard, one slot per rob index
  logic [63:0]  exp_value [16];
  logic [5:0]   exp_preg  [16];
  logic         exp_taken [16];
  logic         live      [16];
  int           avail     [16];   // edge at which the result sits in its queue

  integer       seed;
  string        test_name;
  int           checks     = 0;
  int           errors     = 0;
  int           err_start  = 0;
  int           cycle      = 0;   // posedge count, bumped at each negedge
  int           live_count = 0;
  int           window     = 0;   // ops issued since the head moved
  logic [3:0]   next_rob   = '0;
  logic [3:0]   head       = '0;
  logic         last_valid = 1'b0;
  exec_pkg::fu_sel_e last_fu = exec_pkg::fu_alu;

  exec_cluster #(
    .mult_stages (mult_stages),
    .queue_depth (queue_depth)
  ) uut (
    .clock            (clock),
    .reset            (reset),
    .issue_valid      (issue_valid),
    .issue_fu         (issue_fu),
    .issue_op         (issue_op),
    .issue_a          (issue_a),
    .issue_b          (issue_b),
    .issue_dest_preg  (issue_dest_preg),
    .issue_rob_idx    (issue_rob_idx),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .alu_ready        (alu_ready),
    .mult_ready       (mult_ready),
    .cdb_valid        (cdb_valid),
    .cdb_preg         (cdb_preg),
    .cdb_value        (cdb_value),
    .cdb_rob_idx      (cdb_rob_idx),
    .cdb_taken        (cdb_taken)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////
  // reference model
  ////////////////////

  // {taken, value} as the cdb should carry it
  function automatic logic [64:0] expected_result(input exec_pkg::fu_sel_e fu,
                                                  input exec_pkg::alu_op_e op,
                                                  input logic [63:0] a,
                                                  input logic [63:0] b);
    logic [63:0] v;
    logic        t;
    v = '0;
    t = 1'b0;
    if (fu == exec_pkg::fu_mult) begin
      v = a * b;  // low word of the product
    end else begin
      case (op)
        exec_pkg::alu_add: v = a + b;
        exec_pkg::alu_sub: v = a - b;
        exec_pkg::alu_and: v = a & b;
        exec_pkg::alu_or:  v = a | b;
        exec_pkg::alu_xor: v = a ^ b;
        exec_pkg::alu_sll: v = a << b[5:0];
        exec_pkg::alu_srl: v = a >> b[5:0];
        exec_pkg::alu_slt: v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        exec_pkg::alu_beq: t = (a == b);
        exec_pkg::alu_bne: t = (a != b);
        default:           v = '0;
      endcase
    end
    return {t, v};
  endfunction

  function automatic logic [3:0] age_of(input logic [3:0] idx);
    return 4'(idx - head);  // 0 is the rob head
  endfunction

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic abort(input string why);
    $display("timeout while %s", why);
    $display("test failed");
    $finish;
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic idle();
    @(posedge clock);
    issue_valid <= 1'b0;
    rollback_en <= 1'b0;
    last_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (live_count != 0) begin
      idle();
      waited++;
      if (waited > timeout) abort("waiting for the scoreboard to drain");
    end
  endtask

  // move the rob head to the next free index
  task automatic open_window();
    idle();
    rob_head_idx <= next_rob;
    head = next_rob;
    window = 0;
  endtask

  // ready seen at the negedge holds at the next edge unless that unit issued
  function automatic logic can_issue(input exec_pkg::fu_sel_e fu);
    logic rdy;
    rdy = (fu == exec_pkg::fu_alu) ? alu_ready : mult_ready;
    return rdy && !(last_valid && last_fu == fu);
  endfunction

  task automatic issue(input exec_pkg::fu_sel_e fu, input exec_pkg::alu_op_e op,
                       input logic [63:0] a, input logic [63:0] b);
    logic [64:0] r;
    logic [5:0]  preg;
    int          waited;
    if (window == 16) begin
      wait_drain();
      open_window();
    end
    waited = 0;
    preg = 6'($random(seed));
    @(negedge clock);
    while (!can_issue(fu)) begin
      idle();
      waited++;
      if (waited > timeout) abort("waiting for a unit to become ready");
      @(negedge clock);
    end
    @(posedge clock);
    rollback_en     <= 1'b0;
    issue_valid     <= 1'b1;
    issue_fu        <= fu;
    issue_op        <= op;
    issue_a         <= a;
    issue_b         <= b;
    issue_dest_preg <= preg;
    issue_rob_idx   <= next_rob;
    r = expected_result(fu, op, a, b);
    exp_value[next_rob] = r[63:0];
    exp_taken[next_rob] = r[64];
    exp_preg[next_rob]  = preg;
    live[next_rob]      = 1'b1;
    avail[next_rob]     = cycle + 1 + ((fu == exec_pkg::fu_mult) ? mult_stages : 0);
    live_count++;
    last_valid = 1'b1;
    last_fu    = fu;
    next_rob++;
    window++;
  endtask

  task automatic issue_alu(input exec_pkg::alu_op_e op, input logic [63:0] a,
                           input logic [63:0] b);
    issue(exec_pkg::fu_alu, op, a, b);
  endtask

  task automatic issue_mult(input logic [63:0] a, input logic [63:0] b);
    issue(exec_pkg::fu_mult, exec_pkg::alu_add, a, b);
  endtask

  // pulse rollback, then drop every younger op from the scoreboard
  task automatic rollback_at(input logic [3:0] idx);
    @(posedge clock);
    issue_valid      <= 1'b0;
    rollback_en      <= 1'b1;
    rollback_rob_idx <= idx;
    last_valid = 1'b0;
    @(posedge clock);
    rollback_en <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      if (live[i] && age_of(4'(i)) > age_of(idx)) begin
        live[i] = 1'b0;
        live_count--;
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    $display("%-10s done, %0d errors", test_name, errors - err_start);
  endtask

  ////////////////////
  // compare process
  ////////////////////

  logic       have_prev = 1'b0;
  logic [3:0] prev_idx  = '0;
  int         prev_edge = 0;

  always @(negedge clock) begin : compare
    logic [3:0] idx;
    idx = cdb_rob_idx;
    if (!reset && cdb_valid === 1'b1) begin
      if (!live[idx]) begin
        errors++;
        $display("%s: broadcast for rob_idx %0d that is not in flight", test_name, idx);
      end else begin
        check("value", exp_value[idx], cdb_value);
        check("preg", 64'(exp_preg[idx]), 64'(cdb_preg));
        check("taken", 64'(exp_taken[idx]), 64'(cdb_taken));
        // this one was queued when the previous one won, so it must be younger
        if (have_prev && avail[idx] < prev_edge) begin
          check("older first", 64'd1, 64'(age_of(prev_idx) < age_of(idx)));
        end
        live[idx] = 1'b0;
        live_count--;
      end
      have_prev = 1'b1;
      prev_idx  = idx;
      prev_edge = cycle;
    end
    cycle++;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    int          pick;
    seed             = 64;
    reset            = 1'b1;
    issue_valid      = 1'b0;
    issue_fu         = exec_pkg::fu_alu;
    issue_op         = exec_pkg::alu_add;
    issue_a          = '0;
    issue_b          = '0;
    issue_dest_preg  = '0;
    issue_rob_idx    = '0;
    rollback_en      = 1'b0;
    rollback_rob_idx = '0;
    rob_head_idx     = '0;
    for (int i = 0; i < 16; i++) begin
      live[i] = 1'b0;
    end
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    begin_test("reset");
    repeat (4) begin
      idle();
      @(negedge clock);
      check("alu_ready", 64'd1, 64'(alu_ready));
      check("mult_ready", 64'd1, 64'(mult_ready));
      check("cdb_valid", 64'd0, 64'(cdb_valid));
    end
    end_test();

    begin_test("alu");
    issue_alu(exec_pkg::alu_add, 64'd5, 64'd7);
    issue_alu(exec_pkg::alu_add, '1, 64'd1);                       // wraps to zero
    issue_alu(exec_pkg::alu_sub, 64'd3, 64'd5);
    issue_alu(exec_pkg::alu_and, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0);
    issue_alu(exec_pkg::alu_or,  64'hf000_0000_0000_000f, 64'h0000_ffff_0000_0000);
    issue_alu(exec_pkg::alu_xor, 64'haaaa_5555_aaaa_5555, '1);
    issue_alu(exec_pkg::alu_sll, 64'd1, 64'd63);                   // top bit
    issue_alu(exec_pkg::alu_sll, 64'h1234, 64'd67);                // only 6 bits of b count
    issue_alu(exec_pkg::alu_sll, 64'hdead_beef, 64'd0);
    issue_alu(exec_pkg::alu_srl, 64'h8000_0000_0000_0000, 64'd63);
    issue_alu(exec_pkg::alu_srl, '1, 64'h40);                      // shamt wraps to 0
    issue_alu(exec_pkg::alu_slt, '1, 64'd1);                       // -1 < 1
    issue_alu(exec_pkg::alu_slt, 64'd1, '1);
    issue_alu(exec_pkg::alu_slt, 64'h8000_0000_0000_0000, 64'd0);
    issue_alu(exec_pkg::alu_slt, 64'd5, 64'd5);
    issue_alu(exec_pkg::alu_beq, 64'd42, 64'd42);                  // taken
    issue_alu(exec_pkg::alu_beq, 64'd42, 64'd43);
    issue_alu(exec_pkg::alu_bne, 64'd7, 64'd7);
    issue_alu(exec_pkg::alu_bne, 64'd7, 64'd8);                    // taken
    wait_drain();
    end_test();

    begin_test("mult");
    issue_mult(64'd0, 64'h1234_5678);
    issue_mult('1, '1);                                            // -1 * -1
    issue_mult(64'h8000_0000_0000_0000, 64'd2);
    issue_mult(64'h8000_0000_0000_0000, '1);
    issue_mult(64'h1_0000_0000, 64'h1_0000_0000);                  // all in the high word
    issue_mult('1, 64'd3);
    issue_mult(64'd123456789, 64'd987654321);
    repeat (16) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      issue_mult(a, b);
    end
    wait_drain();
    end_test();

    begin_test("mixed");
    repeat (64) begin
      a    = {$random(seed), $random(seed)};
      b    = {$random(seed), $random(seed)};
      pick = $unsigned($random(seed)) % 4;
      if (pick == 0) b = a;                                        // lets branches resolve equal
      pick = $unsigned($random(seed)) % 20;
      if (pick >= 10) issue_mult(a, b);
      else issue_alu(exec_pkg::alu_op_e'(4'(pick)), a, b);
    end
    wait_drain();
    end_test();

    // older mults still in flight when the branch resolves wrong
    begin_test("rollback");
    open_window();
    issue_mult(64'd11, 64'd13);
    issue_alu(exec_pkg::alu_add, 64'd100, 64'd1);
    issue_mult({$random(seed), $random(seed)}, 64'd3);
    issue_alu(exec_pkg::alu_beq, 64'd9, 64'd9);                    // the branch
    issue_mult(64'd17, 64'd19);                                    // younger
    issue_alu(exec_pkg::alu_xor, 64'hffff, 64'h00ff);              // younger
    rollback_at(4'(next_rob - 3));
    wait_drain();
    repeat (8) idle();                                             // nothing young may show up late
    end_test();

    errors = errors + uut.props.fail_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/exec_cluster_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_props (
  input logic                       clock,
  input logic                       reset,
  input logic                       issue_valid,
  input exec_pkg::fu_sel_e          issue_fu,
  input logic                       alu_ready,
  input logic                       mult_ready,
  input logic                       rollback_en,
  input exec_pkg::rob_idx_t         rollback_rob_idx,
  input exec_pkg::rob_idx_t         rob_head_idx,
  input logic                       cdb_valid,
  input logic [exec_pkg::xlen-1:0]  cdb_value,
  input exec_pkg::rob_idx_t         cdb_rob_idx
);

  int fail_count = 0;  // read by the testbench at the end

  ////////////////////
  // issue side
  ////////////////////

  alu_issue_ready: assert property (@(posedge clock) disable iff (reset)
    issue_valid && issue_fu == exec_pkg::fu_alu |-> alu_ready)
    else begin fail_count++; $error("alu issued while not ready"); end

  mult_issue_ready: assert property (@(posedge clock) disable iff (reset)
    issue_valid && issue_fu == exec_pkg::fu_mult |-> mult_ready)
    else begin fail_count++; $error("multiplier issued while not ready"); end

  ////////////////////
  // cdb side
  ////////////////////

  cdb_quiet_after_reset: assert property (@(posedge clock) reset |=> !cdb_valid)
    else begin fail_count++; $error("cdb_valid high right after reset"); end

  cdb_value_known: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> !$isunknown(cdb_value))
    else begin fail_count++; $error("cdb_value unknown during a broadcast"); end

  // distances taken from the head seen at the rollback edge
  cdb_no_young_after_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback_en |=> !cdb_valid ||
      (4'(cdb_rob_idx - $past(rob_head_idx)) <=
       4'($past(rollback_rob_idx) - $past(rob_head_idx))))
    else begin fail_count++; $error("squashed rob_idx broadcast after rollback"); end

endmodule

bind exec_cluster exec_cluster_props props (
  .clock            (clock),
  .reset            (reset),
  .issue_valid      (issue_valid),
  .issue_fu         (issue_fu),
  .alu_ready        (alu_ready),
  .mult_ready       (mult_ready),
  .rollback_en      (rollback_en),
  .rollback_rob_idx (rollback_rob_idx),
  .rob_head_idx     (rob_head_idx),
  .cdb_valid        (cdb_valid),
  .cdb_value        (cdb_value),
  .cdb_rob_idx      (cdb_rob_idx)
);

`default_nettype wire

// File: hdl/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
  parameter int mult_stages = 4,  // multiplier depth, divides xlen
  parameter int queue_depth = 4   // slots per result queue
) (
  input  logic                        clock,
  input  logic                        reset,
  // issue port from the reservation stations
  input  logic                        issue_valid,
  input  exec_pkg::fu_sel_e           issue_fu,
  input  exec_pkg::alu_op_e           issue_op,
  input  logic [exec_pkg::xlen-1:0]   issue_a,
  input  logic [exec_pkg::xlen-1:0]   issue_b,
  input  exec_pkg::preg_idx_t         issue_dest_preg,
  input  exec_pkg::rob_idx_t          issue_rob_idx,
  // rob side
  input  logic                        rollback_en,
  input  exec_pkg::rob_idx_t          rollback_rob_idx,
  input  exec_pkg::rob_idx_t          rob_head_idx,      // also used for age order
  output logic                        alu_ready,
  output logic                        mult_ready,
  // common data bus
  output logic                        cdb_valid,
  output exec_pkg::preg_idx_t         cdb_preg,
  output logic [exec_pkg::xlen-1:0]   cdb_value,
  output exec_pkg::rob_idx_t          cdb_rob_idx,
  output logic                        cdb_taken
);

  logic                        alu_start;
  logic                        mult_start;
  logic                        alu_pop;
  logic                        mult_pop;
  logic                        alu_head_valid;
  logic                        mult_head_valid;
  exec_pkg::alu_result_t       alu_head;
  exec_pkg::mult_result_t      mult_head;

  // steer the issue strobe
  assign alu_start  = issue_valid && (issue_fu == exec_pkg::fu_alu);
  assign mult_start = issue_valid && (issue_fu == exec_pkg::fu_mult);

  alu_unit #(
    .queue_depth (queue_depth)
  ) alu (
    .clock            (clock),
    .reset            (reset),
    .start            (alu_start),
    .op               (issue_op),
    .a                (issue_a),
    .b                (issue_b),
    .dest_preg        (issue_dest_preg),
    .rob_idx          (issue_rob_idx),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .pop              (alu_pop),
    .ready            (alu_ready),
    .head_valid       (alu_head_valid),
    .head             (alu_head)
  );

  mult_unit #(
    .mult_stages (mult_stages),
    .queue_depth (queue_depth)
  ) mult (
    .clock            (clock),
    .reset            (reset),
    .start            (mult_start),
    .a                (issue_a),
    .b                (issue_b),
    .dest_preg        (issue_dest_preg),
    .rob_idx          (issue_rob_idx),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .pop              (mult_pop),
    .ready            (mult_ready),
    .head_valid       (mult_head_valid),
    .head             (mult_head)
  );

  cdb_arbiter arb (
    .clock            (clock),
    .reset            (reset),
    .alu_valid        (alu_head_valid),
    .alu_head         (alu_head),
    .mult_valid       (mult_head_valid),
    .mult_head        (mult_head),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .alu_pop          (alu_pop),
    .mult_pop         (mult_pop),
    .cdb_valid        (cdb_valid),
    .cdb_preg         (cdb_preg),
    .cdb_value        (cdb_value),
    .cdb_rob_idx      (cdb_rob_idx),
    .cdb_taken        (cdb_taken)
  );

endmodule

`default_nettype wire

// File: hdl/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        alu_valid,         // alu queue head live
  input  exec_pkg::alu_result_t       alu_head,
  input  logic                        mult_valid,
  input  exec_pkg::mult_result_t      mult_head,
  input  logic                        rollback_en,
  input  exec_pkg::rob_idx_t          rollback_rob_idx,
  input  exec_pkg::rob_idx_t          rob_head_idx,
  output logic                        alu_pop,
  output logic                        mult_pop,
  output logic                        cdb_valid,         // one pulse per broadcast
  output exec_pkg::preg_idx_t         cdb_preg,
  output logic [exec_pkg::xlen-1:0]   cdb_value,
  output exec_pkg::rob_idx_t          cdb_rob_idx,
  output logic                        cdb_taken
);

  logic                        alu_older;
  logic                        grant_kill;
  exec_pkg::preg_idx_t         grant_preg;
  logic [exec_pkg::xlen-1:0]   grant_value;
  exec_pkg::rob_idx_t          grant_rob;
  logic                        grant_taken;

  ////////////////////
  // oldest first
  ////////////////////

  // rob indices in flight are unique so a tie cannot happen
  assign alu_older = exec_pkg::rob_distance(alu_head.rob_idx, rob_head_idx) <
                     exec_pkg::rob_distance(mult_head.rob_idx, rob_head_idx);

  assign alu_pop  = alu_valid && (!mult_valid || alu_older);
  assign mult_pop = mult_valid && !alu_pop;

  always_comb begin
    if (alu_pop) begin
      grant_preg  = alu_head.dest_preg;
      grant_value = alu_head.value;
      grant_rob   = alu_head.rob_idx;
      grant_taken = alu_head.taken;
    end else begin
      grant_preg  = mult_head.dest_preg;
      grant_value = mult_head.value;
      grant_rob   = mult_head.rob_idx;
      grant_taken = 1'b0;                            // products never branch
    end
  end

  // a head popped on the rollback edge may already be dead
  assign grant_kill = rollback_en &&
    (exec_pkg::rob_distance(grant_rob, rob_head_idx) >
     exec_pkg::rob_distance(rollback_rob_idx, rob_head_idx));

  ////////////////////
  // cdb register
  ////////////////////

  // rewritten every edge, so the held result never survives a rollback
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= (alu_pop || mult_pop) && !grant_kill;
    end
  end

  always_ff @(posedge clock) begin
    cdb_preg    <= grant_preg;
    cdb_value   <= grant_value;
    cdb_rob_idx <= grant_rob;
    cdb_taken   <= grant_taken;
  end

endmodule

`default_nettype wire

// File: hdl/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit #(
  parameter int mult_stages = 4,  // must divide xlen
  parameter int queue_depth = 4
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        start,
  input  logic [exec_pkg::xlen-1:0]   a,
  input  logic [exec_pkg::xlen-1:0]   b,
  input  exec_pkg::preg_idx_t         dest_preg,
  input  exec_pkg::rob_idx_t          rob_idx,
  input  logic                        rollback_en,
  input  exec_pkg::rob_idx_t          rollback_rob_idx,
  input  exec_pkg::rob_idx_t          rob_head_idx,
  input  logic                        pop,
  output logic                        ready,
  output logic                        head_valid,
  output exec_pkg::mult_result_t      head
);

  localparam int xlen  = exec_pkg::xlen;
  localparam int cw    = xlen / mult_stages;                  // multiplier bits per stage
  localparam logic [xlen-1:0] chunk_mask = (xlen'(1) << cw) - 1'b1;
  localparam int last  = mult_stages - 1;

  // per stage pipeline registers
  logic [xlen-1:0]          st_a   [mult_stages];  // multiplicand, pre-shifted
  logic [xlen-1:0]          st_b   [mult_stages];  // remaining multiplier bits
  logic [xlen-1:0]          st_sum [mult_stages];  // running low word
  exec_pkg::preg_idx_t      st_preg[mult_stages];
  exec_pkg::rob_idx_t       st_rob [mult_stages];
  logic [mult_stages-1:0]   st_valid;
  logic [mult_stages-1:0]   st_kill;

  exec_pkg::rob_idx_t                 rb_dist;
  logic                               in_kill;
  logic                               push;
  exec_pkg::mult_result_t             result;
  logic [$clog2(queue_depth+1)-1:0]   free_count;
  logic [$clog2(mult_stages+1)-1:0]   busy;         // valid stages

  assign rb_dist = exec_pkg::rob_distance(rollback_rob_idx, rob_head_idx);
  assign in_kill = rollback_en && (exec_pkg::rob_distance(rob_idx, rob_head_idx) > rb_dist);

  always_comb begin
    busy = '0;
    for (int k = 0; k < mult_stages; k++) begin
      st_kill[k] = rollback_en && (exec_pkg::rob_distance(st_rob[k], rob_head_idx) > rb_dist);
      busy       = busy + st_valid[k];
    end
  end

  ////////////////////
  // shift and add
  ////////////////////

  always_ff @(posedge clock) begin
    st_a[0]    <= a << cw;
    st_b[0]    <= b >> cw;
    st_sum[0]  <= a * (b & chunk_mask);              // chunk 0
    st_preg[0] <= dest_preg;
    st_rob[0]  <= rob_idx;
    for (int k = 1; k < mult_stages; k++) begin
      st_a[k]    <= st_a[k-1] << cw;
      st_b[k]    <= st_b[k-1] >> cw;
      st_sum[k]  <= st_sum[k-1] + st_a[k-1] * (st_b[k-1] & chunk_mask);
      st_preg[k] <= st_preg[k-1];
      st_rob[k]  <= st_rob[k-1];
    end
  end

  // stage valid bits
  always_ff @(posedge clock) begin
    if (reset) begin
      st_valid <= '0;
    end else begin
      st_valid[0] <= start && !in_kill;
      for (int k = 1; k < mult_stages; k++) begin
        st_valid[k] <= st_valid[k-1] && !st_kill[k-1];
      end
    end
  end

  // last stage holds the full product, push on the next edge
  assign push             = st_valid[last] && !st_kill[last];
  assign result.value     = st_sum[last];
  assign result.dest_preg = st_preg[last];
  assign result.rob_idx   = st_rob[last];

  // every in-flight op already owns a queue slot so the pipe never stalls
  assign ready = (free_count > busy);

  result_queue #(
    .payload_t   (exec_pkg::mult_result_t),
    .queue_depth (queue_depth)
  ) queue (
    .clock            (clock),
    .reset            (reset),
    .push             (push),
    .push_data        (result),
    .pop              (pop),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .head_valid       (head_valid),
    .head             (head),
    .free_count       (free_count)
  );

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int queue_depth = 4
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        start,             // issue strobe for this unit
  input  exec_pkg::alu_op_e           op,
  input  logic [exec_pkg::xlen-1:0]   a,
  input  logic [exec_pkg::xlen-1:0]   b,
  input  exec_pkg::preg_idx_t         dest_preg,
  input  exec_pkg::rob_idx_t          rob_idx,
  input  logic                        rollback_en,
  input  exec_pkg::rob_idx_t          rollback_rob_idx,
  input  exec_pkg::rob_idx_t          rob_head_idx,
  input  logic                        pop,
  output logic                        ready,
  output logic                        head_valid,
  output exec_pkg::alu_result_t       head
);

  localparam int shamt_w = $clog2(exec_pkg::xlen);  // 6 bits of b for shifts

  exec_pkg::alu_result_t              result;
  logic                               push;
  logic                               squash_in;
  logic [$clog2(queue_depth+1)-1:0]   free_count;
  logic [shamt_w-1:0]                 shamt;

  assign shamt = b[shamt_w-1:0];

  ////////////////////
  // execute
  ////////////////////

  always_comb begin
    result.dest_preg = dest_preg;
    result.rob_idx   = rob_idx;
    result.taken     = 1'b0;
    case (op)
      exec_pkg::alu_add: result.value = a + b;
      exec_pkg::alu_sub: result.value = a - b;
      exec_pkg::alu_and: result.value = a & b;
      exec_pkg::alu_or:  result.value = a | b;
      exec_pkg::alu_xor: result.value = a ^ b;
      exec_pkg::alu_sll: result.value = a << shamt;
      exec_pkg::alu_srl: result.value = a >> shamt;   // logical
      exec_pkg::alu_slt: result.value = {{(exec_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      exec_pkg::alu_beq: begin
        result.value = '0;                              // branches write nothing useful
        result.taken = (a == b);
      end
      exec_pkg::alu_bne: begin
        result.value = '0;
        result.taken = (a != b);
      end
      default:           result.value = '0;
    endcase
  end

  // an op issued on the rollback edge that is already dead never enters
  assign squash_in = rollback_en &&
    (exec_pkg::rob_distance(rob_idx, rob_head_idx) >
     exec_pkg::rob_distance(rollback_rob_idx, rob_head_idx));
  assign push  = start && !squash_in;
  assign ready = (free_count != '0);  // room for one more push

  ////////////////////
  // completion queue
  ////////////////////

  result_queue #(
    .payload_t   (exec_pkg::alu_result_t),
    .queue_depth (queue_depth)
  ) queue (
    .clock            (clock),
    .reset            (reset),
    .push             (push),
    .push_data        (result),
    .pop              (pop),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_head_idx     (rob_head_idx),
    .head_valid       (head_valid),
    .head             (head),
    .free_count       (free_count)
  );

endmodule

`default_nettype wire

// File: hdl/result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
  parameter type payload_t   = exec_pkg::alu_result_t,
  parameter int  queue_depth = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             push,              // unit result arriving
  input  payload_t                         push_data,
  input  logic                             pop,               // from the arbiter
  input  logic                             rollback_en,
  input  exec_pkg::rob_idx_t               rollback_rob_idx,
  input  exec_pkg::rob_idx_t               rob_head_idx,
  output logic                             head_valid,        // live result at head
  output payload_t                         head,
  output logic [$clog2(queue_depth+1)-1:0] free_count
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);

  payload_t               mem [queue_depth];  // payload storage
  logic [queue_depth-1:0] live;               // per entry valid
  logic [ptr_w-1:0]       head_ptr;
  logic [ptr_w-1:0]       tail_ptr;
  logic [cnt_w-1:0]       count;              // occupied slots, dead ones too
  logic                   advance;
  logic                   accept;
  exec_pkg::rob_idx_t     rb_dist;

  // circular increment, depth need not be a power of two
  function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rb_dist    = exec_pkg::rob_distance(rollback_rob_idx, rob_head_idx);
  assign head_valid = (count != '0) && live[head_ptr];
  assign head       = mem[head_ptr];
  assign free_count = cnt_w'(queue_depth) - count;

  // head moves on a pop or when the head slot was squashed
  assign advance = (count != '0) && (!live[head_ptr] || pop);
  assign accept  = push && ((count != cnt_w'(queue_depth)) || advance);

  // payload write at the tail
  always_ff @(posedge clock) begin
    if (accept) begin
      mem[tail_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      live     <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      // squash everything younger than the mispredicted branch
      if (rollback_en) begin
        for (int i = 0; i < queue_depth; i++) begin
          if (exec_pkg::rob_distance(mem[i].rob_idx, rob_head_idx) > rb_dist) begin
            live[i] <= 1'b0;
          end
        end
      end
      if (advance) begin
        live[head_ptr] <= 1'b0;
        head_ptr       <= bump(head_ptr);
      end
      if (accept) begin              // last so a full wrap keeps the new entry
        live[tail_ptr] <= 1'b1;
        tail_ptr       <= bump(tail_ptr);
      end
      count <= count + cnt_w'(accept) - cnt_w'(advance);
    end
  end

endmodule

`default_nettype wire

// File: hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

  ////////////////////
  // widths and sizes
  ////////////////////

  localparam int xlen       = 64;                // one machine word
  localparam int rob_size   = 16;                // rob entries
  localparam int rob_idx_w  = $clog2(rob_size);  // 4 bits
  localparam int preg_idx_w = 6;                 // 64 physical regs

  typedef logic [rob_idx_w-1:0]  rob_idx_t;
  typedef logic [preg_idx_w-1:0] preg_idx_t;

  ////////////////////
  // opcodes
  ////////////////////

  // target unit of an issued op
  typedef enum logic {
    fu_alu  = 1'b0,
    fu_mult = 1'b1
  } fu_sel_e;

  // alu operations, branches resolve here too
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_sll = 4'd5,
    alu_srl = 4'd6,
    alu_slt = 4'd7,  // signed compare
    alu_beq = 4'd8,
    alu_bne = 4'd9
  } alu_op_e;

  ////////////////////
  // result payloads
  ////////////////////

  typedef struct packed {
    logic [xlen-1:0] value;     // zero for branches
    preg_idx_t       dest_preg;
    rob_idx_t        rob_idx;
    logic            taken;     // branch outcome
  } alu_result_t;

  typedef struct packed {
    logic [xlen-1:0] value;     // low word of the product
    preg_idx_t       dest_preg;
    rob_idx_t        rob_idx;
  } mult_result_t;

  // age of an entry as seen from the rob head, 0 is oldest
  function automatic rob_idx_t rob_distance(input rob_idx_t idx, input rob_idx_t head);
    return rob_idx_t'((int'(idx) + rob_size - int'(head)) % rob_size);
  endfunction

endpackage

`default_nettype wire
